//--- list.f
+incdir+verilog
verilog/cv_map_pkg.sv
verilog/cv_io_pkg.sv
verilog/cv_bus_timing.sv
verilog/cv_addr_dec.sv
verilog/cv_cart_mapper.sv
verilog/cv_ctrl_ports.sv
verilog/cv_glue_top.sv
testbench/tb_cv_glue.sv

//--- run.sh
#!/bin/sh
# Build and run the bus glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cv_glue -f list.f -o tb_cv_glue > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_cv_glue > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

//--- testbench/tb_cv_glue.sv
//----------------------------------------------------------------------
// Bus glue testbench
// Plays the CPU bus master and checks every output against a model
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "cv_defs.svh"

module tb_cv_glue;

  localparam int TIMEOUT_CYCLES = 4000;

  // Expected outputs of one bus cycle
  typedef struct packed {
    logic [7:0]  d;
    logic        bios_ce_n;
    logic        ram_ce_n;
    logic [3:0]  cart_en_n;
    logic        vdp_r_n;
    logic        vdp_w_n;
    logic        psg_we_n;
    logic [19:0] cart_a;
    logic        wait_n;
    logic        cpu_en;
  } exp_t;

  logic clk_i, reset_n_s, clk_en_10m7_i, psg_ready_i;
  logic [15:0] a_i;
  logic [7:0]  d_i, d_o, ram_d_o;
  logic mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i;
  logic [5:0]  cart_pages_i;
  logic [7:0]  bios_d_i, ram_d_i, cart_d_i, vdp_d_i;
  logic [7:0]  key_p1_i, key_p2_i, joy_p1_i, joy_p2_i;
  logic        wait_n_o, cpu_en_o, bios_ce_n_o, ram_ce_n_o;
  logic [12:0] bios_a_o;
  logic [9:0]  ram_a_o;
  logic [19:0] cart_a_o;
  logic [3:0]  cart_en_n_o;
  logic        vdp_r_n_o, vdp_w_n_o, psg_we_n_o;

  // Model state and run bookkeeping
  logic [5:0]  page_m;
  logic        joy_m, wait_m, en_rand, en_force;
  logic [31:0] lfsr_q;
  int          div_m, en_cnt, cpu_cnt, value_errs, other_errs, cycle_cnt;

  cv_glue_top i_cv_glue_top (
    .clk_i, .reset_n_s, .clk_en_10m7_i, .a_i, .d_i, .mreq_n_i, .iorq_n_i,
    .rd_n_i, .wr_n_i, .m1_n_i, .rfsh_n_i, .d_o, .wait_n_o, .cpu_en_o,
    .psg_ready_i, .cart_pages_i, .bios_d_i, .ram_d_i, .cart_d_i, .vdp_d_i,
    .key_p1_i, .key_p2_i, .joy_p1_i, .joy_p2_i, .bios_a_o, .bios_ce_n_o,
    .ram_a_o, .ram_ce_n_o, .ram_d_o, .cart_a_o, .cart_en_n_o, .vdp_r_n_o,
    .vdp_w_n_o, .psg_we_n_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //--------------------------------------------------------------------
  // Random source and reference model
  //--------------------------------------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Outputs expected from the memory map, I/O map and model state
  function automatic exp_t ref_outputs(logic [5:0] page, logic joy, int div, logic wait_q);
    exp_t       e;
    logic       mem, io_rd, io_wr;
    logic [7:0] ctrl;
    mem   = !mreq_n_i && rfsh_n_i && (!rd_n_i || !wr_n_i);
    io_rd = !iorq_n_i && !rd_n_i;
    io_wr = !iorq_n_i && !wr_n_i;
    e.bios_ce_n = !(mem && a_i < 16'h2000);
    e.ram_ce_n  = !(mem && a_i >= 16'h6000 && a_i < 16'h8000);
    // 8 KiB windows from 8000 up
    for (int i = 0; i < 4; i++) e.cart_en_n[i] = !(mem && a_i[15:13] == 3'(4 + i));
    e.vdp_r_n  = !(io_rd && a_i[7:5] == 3'b101);
    e.vdp_w_n  = !(io_wr && a_i[7:5] == 3'b101);
    e.psg_we_n = !(io_wr && a_i[7:5] == 3'b111);
    ctrl = joy ? (a_i[1] ? joy_p2_i : joy_p1_i) : (a_i[1] ? key_p2_i : key_p1_i);
    // Idle bus reads FF, each selected source is ANDed in
    e.d = 8'hFF;
    if (!e.bios_ce_n) e.d = e.d & bios_d_i;
    if (!e.ram_ce_n) e.d = e.d & ram_d_i;
    if (e.cart_en_n != 4'hF) e.d = e.d & cart_d_i;
    if (!e.vdp_r_n) e.d = e.d & vdp_d_i;
    if (io_rd && a_i[7:5] == 3'b111) e.d = e.d & ctrl;
    // Lower 16 KiB fixed to the last page
    e.cart_a = {(a_i >= 16'hC000) ? page : cart_pages_i, a_i[13:0]};
    e.cpu_en = clk_en_10m7_i && div == `CV_CLK_DIV - 1;
    e.wait_n = psg_ready_i && !wait_q;
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    value_errs++;
    $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
  endtask

  //--------------------------------------------------------------------
  // Comparison process
  //--------------------------------------------------------------------
  always @(posedge clk_i) begin
    exp_t e;
    if (!reset_n_s) begin
      page_m = '0;
      joy_m  = 1'b0;
      div_m  = 0;
      wait_m = 1'b0;
    end else begin
      e = ref_outputs(page_m, joy_m, div_m, wait_m);
      if (d_o !== e.d) report_mismatch("d_o", 32'(e.d), 32'(d_o));
      if (bios_ce_n_o !== e.bios_ce_n) report_mismatch("bios_ce_n_o", 32'(e.bios_ce_n), 32'(bios_ce_n_o));
      if (ram_ce_n_o !== e.ram_ce_n) report_mismatch("ram_ce_n_o", 32'(e.ram_ce_n), 32'(ram_ce_n_o));
      if (cart_en_n_o !== e.cart_en_n) report_mismatch("cart_en_n_o", 32'(e.cart_en_n), 32'(cart_en_n_o));
      if (vdp_r_n_o !== e.vdp_r_n) report_mismatch("vdp_r_n_o", 32'(e.vdp_r_n), 32'(vdp_r_n_o));
      if (vdp_w_n_o !== e.vdp_w_n) report_mismatch("vdp_w_n_o", 32'(e.vdp_w_n), 32'(vdp_w_n_o));
      if (psg_we_n_o !== e.psg_we_n) report_mismatch("psg_we_n_o", 32'(e.psg_we_n), 32'(psg_we_n_o));
      if (cart_a_o !== e.cart_a) report_mismatch("cart_a_o", 32'(e.cart_a), 32'(cart_a_o));
      if (wait_n_o !== e.wait_n) report_mismatch("wait_n_o", 32'(e.wait_n), 32'(wait_n_o));
      if (cpu_en_o !== e.cpu_en) report_mismatch("cpu_en_o", 32'(e.cpu_en), 32'(cpu_en_o));
      if (bios_a_o !== a_i[12:0]) report_mismatch("bios_a_o", 32'(a_i[12:0]), 32'(bios_a_o));
      if (ram_a_o !== a_i[9:0]) report_mismatch("ram_a_o", 32'(a_i[9:0]), 32'(ram_a_o));
      if (ram_d_o !== d_i) report_mismatch("ram_d_o", 32'(d_i), 32'(ram_d_o));
      // Advance the model on this edge
      if (clk_en_10m7_i) begin
        en_cnt++;
        div_m = (div_m == `CV_CLK_DIV - 1) ? 0 : div_m + 1;
      end
      if (cpu_en_o) cpu_cnt++;
      if (!mreq_n_i && rfsh_n_i && !rd_n_i && a_i >= 16'hFFC0) page_m = a_i[5:0] & cart_pages_i;
      if (!iorq_n_i && !wr_n_i && a_i[7:5] == 3'b100) joy_m = 1'b0;
      else if (!iorq_n_i && !wr_n_i && a_i[7:5] == 3'b110) joy_m = 1'b1;
      if (m1_n_i) wait_m = 1'b0;
      else if (e.cpu_en) wait_m = !wait_m;
    end
  end

  //--------------------------------------------------------------------
  // Bus master tasks
  //--------------------------------------------------------------------
  // Falling edge, new 10.7 MHz enable
  task automatic next_cycle();
    logic [31:0] b;
    @(negedge clk_i);
    if (en_rand) begin
      take_bits(1, b);
      clk_en_10m7_i = b[0];
    end else begin
      clk_en_10m7_i = en_force;
    end
  endtask

  // One access, stretched while wait_n_o is low
  task automatic bus_cycle(input logic mem, input logic wr, input logic rfsh,
                           input logic [15:0] addr, input logic [7:0] data,
                           output logic [7:0] rdata, output logic [19:0] cart_a);
    logic ready;
    next_cycle();
    a_i = addr;
    d_i = data;
    mreq_n_i = !mem;
    iorq_n_i = mem;
    rd_n_i   = wr;
    wr_n_i   = !wr;
    rfsh_n_i = rfsh;
    do begin
      @(posedge clk_i);
      rdata  = d_o;
      cart_a = cart_a_o;
      ready  = wait_n_o;
      if (!ready) next_cycle();
    end while (!ready);
    next_cycle();
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, rfsh_n_i} = 5'h1F;
  endtask

  task automatic wait_cpu_en();
    logic hit;
    hit = 1'b0;
    while (!hit) begin
      @(posedge clk_i);
      hit = cpu_en_o;
      if (!hit) next_cycle();
    end
  endtask

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------
  initial begin
    logic [31:0] v;
    logic [7:0]  src [8];
    logic [7:0]  rdata;
    logic [19:0] cart_a;
    logic        dup;
    lfsr_q = 32'h9c5f6322;
    {value_errs, other_errs, en_cnt, cpu_cnt} = '0;
    {en_rand, en_force} = 2'b00;
    reset_n_s = 1'b0;
    clk_en_10m7_i = 1'b0;
    psg_ready_i = 1'b1;
    a_i = '0;
    d_i = '0;
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i} = 6'h3F;
    cart_pages_i = 6'h1F;
    // Distinct source bytes, none equal to the idle FF
    for (int i = 0; i < 8; i++) begin
      do begin
        take_bits(8, v);
        dup = (v[7:0] == 8'hFF);
        for (int j = 0; j < i; j++) if (src[j] == v[7:0]) dup = 1'b1;
      end while (dup);
      src[i] = v[7:0];
    end
    {bios_d_i, ram_d_i, cart_d_i, vdp_d_i} = {src[0], src[1], src[2], src[3]};
    {key_p1_i, key_p2_i, joy_p1_i, joy_p2_i} = {src[4], src[5], src[6], src[7]};
    repeat (10) next_cycle();
    reset_n_s = 1'b1;

    // Reset values of CPU enable, page and mode
    // Divider leaves reset at the top, so the first enable is no CPU enable
    en_force = 1'b1;
    next_cycle();
    @(posedge clk_i);
    if (cpu_en_o !== 1'b0) report_mismatch("cpu_en_o", 32'd0, 32'(cpu_en_o));
    en_force = 1'b0;
    bus_cycle(1'b1, 1'b0, 1'b1, 16'hC123, 8'h00, rdata, cart_a);
    if (cart_a[19:14] !== 6'd0) report_mismatch("cart_a_o page", 32'd0, 32'(cart_a[19:14]));
    bus_cycle(1'b0, 1'b0, 1'b1, 16'h00E0, 8'h00, rdata, cart_a);
    if (rdata !== key_p1_i) report_mismatch("d_o", 32'(key_p1_i), 32'(rdata));

    // Divider ratio over random enables
    en_rand = 1'b1;
    repeat (300) next_cycle();
    if (cpu_cnt != en_cnt / 3) report_mismatch("cpu_en_o pulses", 32'(en_cnt / 3), 32'(cpu_cnt));

    // Random memory accesses, a quarter of them refresh
    repeat (200) begin
      take_bits(27, v);
      bus_cycle(1'b1, v[24], v[26:25] != 2'b00, v[15:0], v[23:16], rdata, cart_a);
    end

    // Random I/O accesses
    repeat (100) begin
      take_bits(25, v);
      bus_cycle(1'b0, v[24], 1'b1, v[15:0], v[23:16], rdata, cart_a);
    end

    // Keypad then joystick mode, both players
    bus_cycle(1'b0, 1'b1, 1'b1, 16'h0080, 8'h00, rdata, cart_a);
    bus_cycle(1'b0, 1'b0, 1'b1, 16'h00E0, 8'h00, rdata, cart_a);
    if (rdata !== key_p1_i) report_mismatch("d_o key_p1", 32'(key_p1_i), 32'(rdata));
    bus_cycle(1'b0, 1'b0, 1'b1, 16'h00E2, 8'h00, rdata, cart_a);
    if (rdata !== key_p2_i) report_mismatch("d_o key_p2", 32'(key_p2_i), 32'(rdata));
    bus_cycle(1'b0, 1'b1, 1'b1, 16'h00C0, 8'h00, rdata, cart_a);
    bus_cycle(1'b0, 1'b0, 1'b1, 16'h00E0, 8'h00, rdata, cart_a);
    if (rdata !== joy_p1_i) report_mismatch("d_o joy_p1", 32'(joy_p1_i), 32'(rdata));
    bus_cycle(1'b0, 1'b0, 1'b1, 16'h00E2, 8'h00, rdata, cart_a);
    if (rdata !== joy_p2_i) report_mismatch("d_o joy_p2", 32'(joy_p2_i), 32'(rdata));

    // Page select, then both cartridge halves
    repeat (4) begin
      take_bits(20, v);
      bus_cycle(1'b1, 1'b0, 1'b1, 16'hFFC0 + {10'd0, v[5:0]}, 8'h00, rdata, cart_a);
      bus_cycle(1'b1, 1'b0, 1'b1, {2'b11, v[19:6]}, 8'h00, rdata, cart_a);
      if (cart_a !== {v[5:0] & cart_pages_i, v[19:6]})
        report_mismatch("cart_a_o paged", 32'({v[5:0] & cart_pages_i, v[19:6]}), 32'(cart_a));
      bus_cycle(1'b1, 1'b0, 1'b1, {2'b10, v[19:6]}, 8'h00, rdata, cart_a);
      if (cart_a !== {cart_pages_i, v[19:6]})
        report_mismatch("cart_a_o fixed", 32'({cart_pages_i, v[19:6]}), 32'(cart_a));
    end

    // M1 wait state with a steady enable
    {en_rand, en_force} = 2'b01;
    next_cycle();
    take_bits(16, v);
    a_i = v[15:0];
    {mreq_n_i, rd_n_i, m1_n_i} = 3'b000;
    wait_cpu_en();
    next_cycle();
    if (wait_n_o !== 1'b0) report_mismatch("wait_n_o first", 32'd0, 32'(wait_n_o));
    wait_cpu_en();
    next_cycle();
    if (wait_n_o !== 1'b1) report_mismatch("wait_n_o second", 32'd1, 32'(wait_n_o));
    {mreq_n_i, rd_n_i, m1_n_i} = 3'b111;
    // Sound chip busy
    next_cycle();
    psg_ready_i = 1'b0;
    repeat (6) begin
      next_cycle();
      if (wait_n_o !== 1'b0) report_mismatch("wait_n_o psg", 32'd0, 32'(wait_n_o));
    end
    psg_ready_i = 1'b1;
    repeat (3) next_cycle();

    $display("Errors: %0d mismatches, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Run limit, roughly four times the length of the tests
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    other_errs++;
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d mismatches, %0d other", value_errs, other_errs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verilog/cv_addr_dec.sv
//----------------------------------------------------------------------
// Address decoder
// Memory and I/O addresses to active-low chip selects
//----------------------------------------------------------------------

`timescale 1ns/1ps

module cv_addr_dec (
  input  logic              clk_i,
  input  logic              reset_n_s,
  input  cv_map_pkg::addr_t a_i,
  input  logic              mreq_n_i,
  input  logic              iorq_n_i,
  input  logic              rd_n_i,
  input  logic              wr_n_i,
  input  logic              rfsh_n_i,
  output logic              bios_ce_n_o,
  output logic              ram_ce_n_o,
  output logic [3:0]        cart_en_n_o,
  output logic              page_sel_n_o,
  output logic              vdp_r_n_o,
  output logic              vdp_w_n_o,
  output logic              psg_we_n_o,
  output logic              ctrl_r_n_o,
  output logic              ctrl_key_n_o,
  output logic              ctrl_joy_n_o
);

  logic                 mem_acc_s;
  logic                 mem_rd_s;
  logic                 io_rd_s;
  logic                 io_wr_s;
  cv_io_pkg::io_port_t  port_s;

  //--------------------------------------------------------------------
  // Memory decode
  //--------------------------------------------------------------------
  // Refresh cycles put the row address on the bus, keep them out
  assign mem_acc_s = ~mreq_n_i & rfsh_n_i & (~rd_n_i | ~wr_n_i);
  assign mem_rd_s  = ~mreq_n_i & rfsh_n_i & ~rd_n_i;

  assign bios_ce_n_o = ~(mem_acc_s & (a_i <= cv_map_pkg::BIOS_TOP));
  // Whole 8 KiB window, RAM ignores the upper bits
  assign ram_ce_n_o  = ~(mem_acc_s & (a_i[15:13] == cv_map_pkg::RAM_BASE[15:13]));

  // Cartridge windows
  assign cart_en_n_o[0] = ~(mem_acc_s & (a_i[15:13] == cv_map_pkg::CART_80_BASE[15:13]));
  assign cart_en_n_o[1] = ~(mem_acc_s & (a_i[15:13] == cv_map_pkg::CART_A0_BASE[15:13]));
  assign cart_en_n_o[2] = ~(mem_acc_s & (a_i[15:13] == cv_map_pkg::CART_C0_BASE[15:13]));
  assign cart_en_n_o[3] = ~(mem_acc_s & (a_i[15:13] == cv_map_pkg::CART_E0_BASE[15:13]));

  // Megacart paging, top 64 bytes on read
  assign page_sel_n_o = ~(mem_rd_s & (a_i >= cv_map_pkg::PAGE_SEL_BASE));

  //--------------------------------------------------------------------
  // I/O decode
  //--------------------------------------------------------------------
  assign port_s  = a_i[7:0];
  assign io_rd_s = ~iorq_n_i & ~rd_n_i;
  assign io_wr_s = ~iorq_n_i & ~wr_n_i;

  // Video chip, both directions
  assign vdp_r_n_o = ~(io_rd_s & (port_s[7:5] == cv_io_pkg::IO_VDP[7:5]));
  assign vdp_w_n_o = ~(io_wr_s & (port_s[7:5] == cv_io_pkg::IO_VDP[7:5]));

  // E0 group is shared by sound and controllers
  assign psg_we_n_o = ~(io_wr_s & (port_s[7:5] == cv_io_pkg::IO_SND_CTRL[7:5]));
  assign ctrl_r_n_o = ~(io_rd_s & (port_s[7:5] == cv_io_pkg::IO_SND_CTRL[7:5]));

  // Controller mode strobes
  assign ctrl_key_n_o = ~(io_wr_s & (port_s[7:5] == cv_io_pkg::IO_KEY_MODE[7:5]));
  assign ctrl_joy_n_o = ~(io_wr_s & (port_s[7:5] == cv_io_pkg::IO_JOY_MODE[7:5]));

  // No two memory devices drive the bus together
  a_mem_sel_onehot: assert property (
    @(posedge clk_i) disable iff (!reset_n_s)
    $onehot0({~bios_ce_n_o, ~ram_ce_n_o, ~cart_en_n_o})
  );

endmodule

//--- verilog/cv_bus_timing.sv
//----------------------------------------------------------------------
// CPU bus timing
// Divides the 10.7 MHz enable down to the CPU enable and
// inserts the M1 wait state
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "cv_defs.svh"

module cv_bus_timing (
  input  logic clk_i,
  input  logic reset_n_s,
  input  logic clk_en_10m7_i,
  input  logic m1_n_i,
  input  logic psg_ready_i,
  output logic cpu_en_o,
  output logic wait_n_o
);

  // Reload value of the down counter
  localparam logic [1:0] DIV_LAST = 2'(`CV_CLK_DIV - 1);

  logic [1:0] clk_cnt_q;
  logic       m1_wait_q;

  //--------------------------------------------------------------------
  // Clock enable divider
  //--------------------------------------------------------------------
  // Starts at the top so no enable leaves reset
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      clk_cnt_q <= DIV_LAST;
    end else if (clk_en_10m7_i) begin
      if (clk_cnt_q == 2'd0) begin
        clk_cnt_q <= DIV_LAST;
      end else begin
        clk_cnt_q <= clk_cnt_q - 2'd1;
      end
    end
  end

  // One enable in three
  assign cpu_en_o = clk_en_10m7_i & (clk_cnt_q == 2'd0);

  //--------------------------------------------------------------------
  // M1 wait state
  //--------------------------------------------------------------------
  // Set by first CPU enable of M1, cleared by the second
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      m1_wait_q <= 1'b0;
    end else if (m1_n_i) begin
      m1_wait_q <= 1'b0;
    end else if (cpu_en_o) begin
      m1_wait_q <= ~m1_wait_q;
    end
  end

  // Sound chip busy also holds the CPU
  assign wait_n_o = psg_ready_i & ~m1_wait_q;

  // CPU enable rides on a 10.7 MHz enable and never repeats back to back
  a_cpu_en_spacing: assert property (
    @(posedge clk_i) disable iff (!reset_n_s)
    cpu_en_o |-> clk_en_10m7_i ##1 !cpu_en_o
  );

endmodule

//--- verilog/cv_cart_mapper.sv
//----------------------------------------------------------------------
// Cartridge mapper
// Megacart page register and 20-bit cartridge address
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "cv_defs.svh"

module cv_cart_mapper (
  input  logic                   clk_i,
  input  logic                   reset_n_s,
  input  cv_map_pkg::addr_t      a_i,
  input  logic                   page_sel_n_i,
  input  cv_map_pkg::page_t      cart_pages_i,
  output cv_map_pkg::cart_addr_t cart_a_o
);

  localparam int OFS_W = `CV_CART_A_W - `CV_PAGE_W;

  cv_map_pkg::page_t page_q;
  cv_map_pkg::page_t page_s;

  //--------------------------------------------------------------------
  // Page register
  //--------------------------------------------------------------------
  // Read of FFC0+n selects page n, wrapped to the cartridge size
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      page_q <= '0;
    end else if (!page_sel_n_i) begin
      page_q <= a_i[`CV_PAGE_W-1:0] & cart_pages_i;
    end
  end

  //--------------------------------------------------------------------
  // Address generation
  //--------------------------------------------------------------------
  // Lower 16 KiB is fixed to the last page
  assign page_s = (a_i >= cv_map_pkg::CART_C0_BASE) ? page_q : cart_pages_i;

  // Page number above the 16 KiB offset
  assign cart_a_o = {page_s, a_i[OFS_W-1:0]};

endmodule

//--- verilog/cv_ctrl_ports.sv
//----------------------------------------------------------------------
// Controller ports
// Keypad or joystick mode latch and the player read mux
//----------------------------------------------------------------------

`timescale 1ns/1ps

module cv_ctrl_ports (
  input  logic              clk_i,
  input  logic              reset_n_s,
  input  logic              a1_i,
  input  logic              ctrl_key_n_i,
  input  logic              ctrl_joy_n_i,
  input  cv_map_pkg::data_t key_p1_i,
  input  cv_map_pkg::data_t key_p2_i,
  input  cv_map_pkg::data_t joy_p1_i,
  input  cv_map_pkg::data_t joy_p2_i,
  output cv_map_pkg::data_t d_o
);

  cv_io_pkg::ctrl_mode_t mode_q;

  //--------------------------------------------------------------------
  // Mode latch
  //--------------------------------------------------------------------
  // Write to 80 scans keypad, write to C0 scans joystick
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      mode_q <= cv_io_pkg::CTRL_KEYPAD;
    end else if (!ctrl_key_n_i) begin
      mode_q <= cv_io_pkg::CTRL_KEYPAD;
    end else if (!ctrl_joy_n_i) begin
      mode_q <= cv_io_pkg::CTRL_JOY;
    end
  end

  //--------------------------------------------------------------------
  // Read mux
  //--------------------------------------------------------------------
  // A1 picks the player, mode picks the half of the controller
  always_comb begin
    if (mode_q == cv_io_pkg::CTRL_KEYPAD) begin
      d_o = a1_i ? key_p2_i : key_p1_i;
    end else begin
      d_o = a1_i ? joy_p2_i : joy_p1_i;
    end
  end

  // Decoder never strobes both modes in one access
  a_mode_sel_excl: assert property (
    @(posedge clk_i) disable iff (!reset_n_s)
    !(!ctrl_key_n_i && !ctrl_joy_n_i)
  );

endmodule

//--- verilog/cv_defs.svh
//----------------------------------------------------------------------
// Console bus glue widths and divider settings
// Shared by the map package and the RTL blocks
//----------------------------------------------------------------------

`ifndef CV_DEFS_SVH
`define CV_DEFS_SVH

// CPU bus widths
`define CV_ADDR_W 16
`define CV_DATA_W 8

// Cartridge paging
// 16 KiB pages, up to 64 of them
`define CV_PAGE_W 6
`define CV_CART_A_W 20

// Mirrored work RAM, 1 KiB
`define CV_RAM_A_W 10

// 10.7 MHz enables per CPU enable (3.58 MHz)
`define CV_CLK_DIV 3

`endif

//--- verilog/cv_glue_top.sv
//----------------------------------------------------------------------
// Console bus glue top
// Bus timing, decode, cartridge paging, controllers and the
// masked-AND read data mux
//----------------------------------------------------------------------

`timescale 1ns/1ps
`include "cv_defs.svh"

module cv_glue_top (
  input  logic                   clk_i,
  input  logic                   reset_n_s,
  input  logic                   clk_en_10m7_i,
  // CPU bus
  input  cv_map_pkg::addr_t      a_i,
  input  cv_map_pkg::data_t      d_i,
  input  logic                   mreq_n_i,
  input  logic                   iorq_n_i,
  input  logic                   rd_n_i,
  input  logic                   wr_n_i,
  input  logic                   m1_n_i,
  input  logic                   rfsh_n_i,
  output cv_map_pkg::data_t      d_o,
  output logic                   wait_n_o,
  output logic                   cpu_en_o,
  input  logic                   psg_ready_i,
  input  cv_map_pkg::page_t      cart_pages_i,
  // Read sources
  input  cv_map_pkg::data_t      bios_d_i,
  input  cv_map_pkg::data_t      ram_d_i,
  input  cv_map_pkg::data_t      cart_d_i,
  input  cv_map_pkg::data_t      vdp_d_i,
  // Controllers
  input  cv_map_pkg::data_t      key_p1_i,
  input  cv_map_pkg::data_t      key_p2_i,
  input  cv_map_pkg::data_t      joy_p1_i,
  input  cv_map_pkg::data_t      joy_p2_i,
  // Memory and chip selects
  output logic [12:0]            bios_a_o,
  output logic                   bios_ce_n_o,
  output cv_map_pkg::ram_addr_t  ram_a_o,
  output logic                   ram_ce_n_o,
  output cv_map_pkg::data_t      ram_d_o,
  output cv_map_pkg::cart_addr_t cart_a_o,
  output logic [3:0]             cart_en_n_o,
  output logic                   vdp_r_n_o,
  output logic                   vdp_w_n_o,
  output logic                   psg_we_n_o
);

  logic              page_sel_n_s;
  logic              ctrl_r_n_s;
  logic              ctrl_key_n_s;
  logic              ctrl_joy_n_s;
  cv_map_pkg::data_t d_ctrl_s;

  //--------------------------------------------------------------------
  // Blocks on the shared bus
  //--------------------------------------------------------------------
  cv_bus_timing i_cv_bus_timing (
    .clk_i         (clk_i),
    .reset_n_s     (reset_n_s),
    .clk_en_10m7_i (clk_en_10m7_i),
    .m1_n_i        (m1_n_i),
    .psg_ready_i   (psg_ready_i),
    .cpu_en_o      (cpu_en_o),
    .wait_n_o      (wait_n_o)
  );

  cv_addr_dec i_cv_addr_dec (
    .clk_i        (clk_i),
    .reset_n_s    (reset_n_s),
    .a_i          (a_i),
    .mreq_n_i     (mreq_n_i),
    .iorq_n_i     (iorq_n_i),
    .rd_n_i       (rd_n_i),
    .wr_n_i       (wr_n_i),
    .rfsh_n_i     (rfsh_n_i),
    .bios_ce_n_o  (bios_ce_n_o),
    .ram_ce_n_o   (ram_ce_n_o),
    .cart_en_n_o  (cart_en_n_o),
    .page_sel_n_o (page_sel_n_s),
    .vdp_r_n_o    (vdp_r_n_o),
    .vdp_w_n_o    (vdp_w_n_o),
    .psg_we_n_o   (psg_we_n_o),
    .ctrl_r_n_o   (ctrl_r_n_s),
    .ctrl_key_n_o (ctrl_key_n_s),
    .ctrl_joy_n_o (ctrl_joy_n_s)
  );

  cv_cart_mapper i_cv_cart_mapper (
    .clk_i        (clk_i),
    .reset_n_s    (reset_n_s),
    .a_i          (a_i),
    .page_sel_n_i (page_sel_n_s),
    .cart_pages_i (cart_pages_i),
    .cart_a_o     (cart_a_o)
  );

  cv_ctrl_ports i_cv_ctrl_ports (
    .clk_i        (clk_i),
    .reset_n_s    (reset_n_s),
    .a1_i         (a_i[1]),
    .ctrl_key_n_i (ctrl_key_n_s),
    .ctrl_joy_n_i (ctrl_joy_n_s),
    .key_p1_i     (key_p1_i),
    .key_p2_i     (key_p2_i),
    .joy_p1_i     (joy_p1_i),
    .joy_p2_i     (joy_p2_i),
    .d_o          (d_ctrl_s)
  );

  // Memory address and write data straight from the bus
  assign bios_a_o = a_i[12:0];
  assign ram_a_o  = a_i[`CV_RAM_A_W-1:0];
  assign ram_d_o  = d_i;

  //--------------------------------------------------------------------
  // Read data mux
  //--------------------------------------------------------------------
  // Unselected sources float high, so idle bus reads FF
  always_comb begin
    cv_map_pkg::data_t d_bios_v;
    cv_map_pkg::data_t d_ram_v;
    cv_map_pkg::data_t d_cart_v;
    cv_map_pkg::data_t d_vdp_v;
    cv_map_pkg::data_t d_ctrl_v;

    d_bios_v = bios_ce_n_o   ? '1 : bios_d_i;
    d_ram_v  = ram_ce_n_o    ? '1 : ram_d_i;
    // Any of the four windows
    d_cart_v = &cart_en_n_o  ? '1 : cart_d_i;
    d_vdp_v  = vdp_r_n_o     ? '1 : vdp_d_i;
    d_ctrl_v = ctrl_r_n_s    ? '1 : d_ctrl_s;

    d_o = d_bios_v & d_ram_v & d_cart_v & d_vdp_v & d_ctrl_v;
  end

endmodule

//--- verilog/cv_io_pkg.sv
//----------------------------------------------------------------------
// I/O map package
// Low port address type, port groups and controller mode
//----------------------------------------------------------------------

package cv_io_pkg;

  // Only the low byte of the address is decoded on I/O cycles
  typedef logic [7:0] io_port_t;

  // Controller scan mode
  typedef enum logic {
    CTRL_KEYPAD = 1'b0,
    CTRL_JOY    = 1'b1
  } ctrl_mode_t;

  // Port groups, decoded on bits 7:5
  localparam io_port_t IO_KEY_MODE = 8'h80;
  localparam io_port_t IO_VDP      = 8'hA0;
  localparam io_port_t IO_JOY_MODE = 8'hC0;
  // Sound chip on write, controllers on read
  localparam io_port_t IO_SND_CTRL = 8'hE0;

endpackage

//--- verilog/cv_map_pkg.sv
//----------------------------------------------------------------------
// Memory map package
// Bus types and the base addresses of the memory regions
//----------------------------------------------------------------------

`include "cv_defs.svh"

package cv_map_pkg;

  // Bus and memory types
  typedef logic [`CV_ADDR_W-1:0]   addr_t;
  typedef logic [`CV_DATA_W-1:0]   data_t;
  typedef logic [`CV_PAGE_W-1:0]   page_t;
  typedef logic [`CV_CART_A_W-1:0] cart_addr_t;
  typedef logic [`CV_RAM_A_W-1:0]  ram_addr_t;

  // BIOS ROM, 8 KiB from 0000
  localparam addr_t BIOS_TOP      = 16'h1FFF;

  // RAM window, 1 KiB mirrored through 8 KiB
  localparam addr_t RAM_BASE      = 16'h6000;

  // Cartridge windows, 8 KiB each
  localparam addr_t CART_80_BASE  = 16'h8000;
  localparam addr_t CART_A0_BASE  = 16'hA000;
  localparam addr_t CART_C0_BASE  = 16'hC000;
  localparam addr_t CART_E0_BASE  = 16'hE000;

  // Megacart page select reads
  localparam addr_t PAGE_SEL_BASE = 16'hFFC0;

endpackage
